// ==== hdl/noc_router_config.svh ====
// Router sizing for a single 2x2 node; ids LOCAL_BASE..LOCAL_LAST exit port 0, all others port 1
`ifndef NOC_ROUTER_CONFIG_SVH
`define NOC_ROUTER_CONFIG_SVH

// ***************************************************************************
// Network sizing
// ***************************************************************************

// Node id width, eight nodes in the network
`define NOC_NODE_ID_BW 3

// Flit payload width
`define NOC_DATA_BW 16

// Tag field fills what the two ids leave of a head payload
`define NOC_TAG_BW (`NOC_DATA_BW - 2 * `NOC_NODE_ID_BW)

// Inputs and outputs of this router
`define NOC_NUM_PORTS 2

// ***************************************************************************
// Routing range of this router
// ***************************************************************************

// Ids in this range leave through output 0
`define NOC_LOCAL_BASE 0
`define NOC_LOCAL_LAST 3

`endif

// ==== hdl/noc_router_pkg.sv ====
// Flit and route types; payload is decoded as head view or body view by the flit head mark only
`include "noc_router_config.svh"

package noc_router_pkg;

	// Head flit payload layout, destination in the top bits
	typedef struct packed {
		logic [`NOC_NODE_ID_BW-1:0] dest_id;
		logic [`NOC_NODE_ID_BW-1:0] src_id;
		logic [`NOC_TAG_BW-1:0]     tag;
	} flit_head_t;

	// Body flit payload layout
	typedef struct packed {
		logic [`NOC_DATA_BW-1:0] data;
	} flit_body_t;

	// Same payload word, two readings
	typedef union packed {
		flit_head_t hdr;
		flit_body_t body;
	} flit_payload_u;

	// One link word
	typedef struct packed {
		logic          head;
		logic          tail;
		flit_payload_u payload;
	} flit_t;

	// One-hot output request
	typedef logic [`NOC_NUM_PORTS-1:0] port_sel_t;

	// Local range goes to port 0, everything else to port 1
	// Offset compare keeps the range check unsigned and wrap free
	function automatic port_sel_t route_for_dest(input logic [`NOC_NODE_ID_BW-1:0] dest_id);
		logic [`NOC_NODE_ID_BW-1:0] offs;
		port_sel_t                  sel;
		offs = dest_id - `NOC_NODE_ID_BW'(`NOC_LOCAL_BASE);
		sel = '0;
		if (offs <= `NOC_NODE_ID_BW'(`NOC_LOCAL_LAST - `NOC_LOCAL_BASE))
			sel[0] = 1'b1;
		else
			sel[1] = 1'b1;
		return sel;
	endfunction

endpackage

// ==== hdl/flit_slice.sv ====
// One-entry valid/ready slice; full throughput needs the sink to take out_flit in the same cycle
`timescale 1ns/1ps

module flit_slice
(
	input  logic                  munoc_port_0,
	input  logic                  munoc_port_4,
	input  noc_router_pkg::flit_t in_flit,
	input  logic                  in_valid,
	output logic                  in_ready,
	output noc_router_pkg::flit_t out_flit,
	output logic                  out_valid,
	input  logic                  out_ready
);

	import noc_router_pkg::*;

	// Occupancy of the single entry
	logic  full;
	// Stored flit behind the full bit
	flit_t data_q;

	// Room when empty or when the sink drains the entry this cycle
	assign in_ready = !full || out_ready;

	// ***********************************************************************
	// Storage
	// ***********************************************************************

	// Full bit follows the input valid on every load
	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (!munoc_port_4)
			full <= 1'b0;
		else if (in_ready)
			full <= in_valid;
	end

	// Entry reloads on the same condition
	always_ff @(posedge munoc_port_0)
	begin
		if (in_ready)
			data_q <= in_flit;
	end

	assign out_flit  = data_q;
	assign out_valid = full;

	// A stalled flit must not change or drop before the sink takes it
	a_hold_stable : assert property (
		@(posedge munoc_port_0) disable iff (!munoc_port_4)
		out_valid && !out_ready |=> out_valid && $stable(out_flit)
	);

endmodule

// ==== hdl/route_input_stage.sv ====
// Input stage for one link; assumes every packet starts with a head flit and ends with a tail
`timescale 1ns/1ps
`include "noc_router_config.svh"

module route_input_stage
(
	input  logic                      munoc_port_0,
	input  logic                      munoc_port_4,
	input  noc_router_pkg::flit_t     link_flit,
	input  logic                      link_valid,
	output logic                      link_ready,
	output noc_router_pkg::flit_t     held_flit,
	output logic                      held_valid,
	input  logic                      held_ready,
	output noc_router_pkg::port_sel_t request
);

	import noc_router_pkg::*;

	// Flit taken from the link this cycle
	logic                       link_accept;
	// Packet boundary state, high while waiting for a head
	logic                       expect_head;
	// Destination of the packet now in flight
	logic [`NOC_NODE_ID_BW-1:0] dest_q;

	// ***********************************************************************
	// Buffering
	// ***********************************************************************

	// One-entry slice gives the single cycle of latency
	flit_slice u_slice
	(
		.munoc_port_0 (munoc_port_0),
		.munoc_port_4 (munoc_port_4),
		.in_flit      (link_flit),
		.in_valid     (link_valid),
		.in_ready     (link_ready),
		.out_flit     (held_flit),
		.out_valid    (held_valid),
		.out_ready    (held_ready)
	);

	assign link_accept = link_valid && link_ready;

	// ***********************************************************************
	// Packet boundary tracking
	// ***********************************************************************

	// Next flit is a head after reset and after every tail
	// Single-flit packets carry both marks and keep the state set
	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (!munoc_port_4)
			expect_head <= 1'b1;
		else if (link_accept)
			expect_head <= link_flit.tail;
	end

	// Destination taken from the head view, at the edge the head enters the slice
	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (!munoc_port_4)
			dest_q <= '0;
		else if (link_accept && expect_head)
			dest_q <= link_flit.payload.hdr.dest_id;
	end

	// ***********************************************************************
	// Routing
	// ***********************************************************************

	// Same request for all flits of the packet
	// Dropped whenever the slice holds nothing
	assign request = route_for_dest(dest_q) & {`NOC_NUM_PORTS{held_valid}};

	// Head mark must line up with the tracked boundary
	a_head_framing : assert property (
		@(posedge munoc_port_0) disable iff (!munoc_port_4)
		link_accept |-> (link_flit.head == expect_head)
	);

endmodule

// ==== hdl/output_arbiter.sv ====
// Packet-locked round-robin for one output; an offered head holds the port until its tail transfers
`timescale 1ns/1ps
`include "noc_router_config.svh"

module output_arbiter
(
	input  logic                        munoc_port_0,
	input  logic                        munoc_port_4,
	input  noc_router_pkg::flit_t       cand_flit [`NOC_NUM_PORTS],
	input  logic [`NOC_NUM_PORTS-1:0]   cand_valid,
	input  logic [`NOC_NUM_PORTS-1:0]   cand_request,
	output logic [`NOC_NUM_PORTS-1:0]   grant_ready,
	output noc_router_pkg::flit_t       out_flit,
	output logic                        out_valid,
	input  logic                        out_ready
);

	import noc_router_pkg::*;

	localparam int NUM_IN = `NOC_NUM_PORTS;
	localparam int PTR_BW = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

	// Live requests and the round-robin choice
	logic [NUM_IN-1:0] req_live;
	logic [NUM_IN-1:0] pick;
	logic [NUM_IN-1:0] grant;
	logic [PTR_BW-1:0] grant_idx;
	// Lock state and priority pointer
	logic              locked;
	logic [NUM_IN-1:0] lock_grant;
	logic [PTR_BW-1:0] rr_ptr;
	logic              xfer;

	assign req_live = cand_request & cand_valid;

	// ***********************************************************************
	// Grant selection
	// ***********************************************************************

	// First live request at or after the pointer
	always_comb
	begin
		int  cand_idx;
		logic found;
		pick = '0;
		found = 1'b0;
		for (int k = 0; k < NUM_IN; k++)
		begin
			cand_idx = (int'(rr_ptr) + k) % NUM_IN;
			if (!found && req_live[cand_idx])
			begin
				pick[cand_idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// Locked packet keeps its input
	assign grant = locked ? lock_grant : pick;

	// Index of the granted input for the pointer update
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < NUM_IN; i++)
			if (grant[i])
				grant_idx = PTR_BW'(i);
	end

	// Output mux
	always_comb
	begin
		out_flit = '0;
		for (int i = 0; i < NUM_IN; i++)
			if (grant[i])
				out_flit = cand_flit[i];
	end

	assign out_valid   = |(grant & cand_valid);
	assign grant_ready = grant & {NUM_IN{out_ready}};
	assign xfer        = out_valid && out_ready;

	// ***********************************************************************
	// Lock and pointer
	// ***********************************************************************

	// Tail transfer releases the port and moves priority past the owner
	// An offered head locks at once so a stalled head keeps its input
	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (!munoc_port_4)
		begin
			locked     <= 1'b0;
			lock_grant <= '0;
			rr_ptr     <= '0;
		end
		else if (xfer && out_flit.tail)
		begin
			locked <= 1'b0;
			rr_ptr <= (grant_idx == PTR_BW'(NUM_IN - 1)) ? '0 : grant_idx + 1'b1;
		end
		else if (out_valid && out_flit.head)
		begin
			locked     <= 1'b1;
			lock_grant <= grant;
		end
	end

	// At most one input owns the port
	a_grant_onehot : assert property (
		@(posedge munoc_port_0) disable iff (!munoc_port_4)
		$onehot0(grant)
	);

	// Owner holds until its tail goes out
	a_grant_locked : assert property (
		@(posedge munoc_port_0) disable iff (!munoc_port_4)
		locked && !(xfer && out_flit.tail) |=> $stable(grant)
	);

	// Unlocked port only ever starts with a head from an input stage
	a_start_head : assert property (
		@(posedge munoc_port_0) disable iff (!munoc_port_4)
		out_valid && !locked |-> out_flit.head
	);

endmodule

// ==== hdl/noc_router_top.sv ====
// 2x2 wormhole router; no virtual channels or credits, back-pressure only through ready
`timescale 1ns/1ps
`include "noc_router_config.svh"

module noc_router_top
(
	input  logic                      munoc_port_0,
	input  logic                      munoc_port_4,
	input  noc_router_pkg::flit_t     in_flit   [`NOC_NUM_PORTS],
	input  logic [`NOC_NUM_PORTS-1:0] in_valid,
	output logic [`NOC_NUM_PORTS-1:0] in_ready,
	output noc_router_pkg::flit_t     out_flit  [`NOC_NUM_PORTS],
	output logic [`NOC_NUM_PORTS-1:0] out_valid,
	input  logic [`NOC_NUM_PORTS-1:0] out_ready
);

	import noc_router_pkg::*;

	// Input stage side
	flit_t                     held_flit  [`NOC_NUM_PORTS];
	logic [`NOC_NUM_PORTS-1:0] held_valid;
	logic [`NOC_NUM_PORTS-1:0] held_ready;
	port_sel_t                 request    [`NOC_NUM_PORTS];
	// Per output, indexed by input
	logic [`NOC_NUM_PORTS-1:0] port_req   [`NOC_NUM_PORTS];
	logic [`NOC_NUM_PORTS-1:0] grant_rdy  [`NOC_NUM_PORTS];
	// Per input, indexed by output
	logic [`NOC_NUM_PORTS-1:0] rdy_to_in  [`NOC_NUM_PORTS];

	for (genvar gi = 0; gi < `NOC_NUM_PORTS; gi++)
	begin : g_in
		route_input_stage u_in
		(
			.munoc_port_0 (munoc_port_0),
			.munoc_port_4 (munoc_port_4),
			.link_flit    (in_flit[gi]),
			.link_valid   (in_valid[gi]),
			.link_ready   (in_ready[gi]),
			.held_flit    (held_flit[gi]),
			.held_valid   (held_valid[gi]),
			.held_ready   (held_ready[gi]),
			.request      (request[gi])
		);

		// Stage drains when any output takes its flit
		assign held_ready[gi] = |rdy_to_in[gi];
	end

	for (genvar go = 0; go < `NOC_NUM_PORTS; go++)
	begin : g_out
		// Transpose request and ready between input and output views
		for (genvar gi = 0; gi < `NOC_NUM_PORTS; gi++)
		begin : g_xp
			assign port_req[go][gi]  = request[gi][go];
			assign rdy_to_in[gi][go] = grant_rdy[go][gi];
		end

		output_arbiter u_out
		(
			.munoc_port_0 (munoc_port_0),
			.munoc_port_4 (munoc_port_4),
			.cand_flit    (held_flit),
			.cand_valid   (held_valid),
			.cand_request (port_req[go]),
			.grant_ready  (grant_rdy[go]),
			.out_flit     (out_flit[go]),
			.out_valid    (out_valid[go]),
			.out_ready    (out_ready[go])
		);
	end

endmodule

// ==== verif/noc_router_tb.sv ====
// Random-traffic testbench for the 2x2 router; sources are told apart by ids carried in the flits
`timescale 1ns/1ps
`include "noc_router_config.svh"

module noc_router_tb;

	import noc_router_pkg::*;

	localparam int NP          = `NOC_NUM_PORTS;
	localparam int TAG_BW      = `NOC_TAG_BW;
	localparam int SEQ_BW      = `NOC_DATA_BW - `NOC_NODE_ID_BW;
	localparam int PKTS        = 60;
	localparam int STALL_LIMIT = 200;
	localparam int DRAIN_LIMIT = 2000;

	logic          munoc_port_0 = 1'b0;
	logic          munoc_port_4;
	flit_t         in_flit  [NP];
	logic [NP-1:0] in_valid;
	logic [NP-1:0] in_ready;
	flit_t         out_flit [NP];
	logic [NP-1:0] out_valid;
	logic [NP-1:0] out_ready = '0;

	// Expected flits per (input, output) pair, index input*NP+output
	flit_t                      exp_q    [NP*NP][$];
	// Destination of the packet entering each input
	logic [`NOC_NODE_ID_BW-1:0] pkt_dest [NP];
	// Destination and source of the packet leaving each output, -1 when idle
	logic [`NOC_NODE_ID_BW-1:0] out_dest [NP];
	int                         owner    [NP] = '{default: -1};

	noc_router_top DUT
	(
		.munoc_port_0 (munoc_port_0),
		.munoc_port_4 (munoc_port_4),
		.in_flit      (in_flit),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.out_flit     (out_flit),
		.out_valid    (out_valid),
		.out_ready    (out_ready)
	);

	always #2 munoc_port_0 = ~munoc_port_0;

	// ***********************************************************************
	// Reporting and reference rules
	// ***********************************************************************

	task automatic fail_now(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] want,
		input logic [31:0] got);
		$display("FAIL time=%0t signal=%s expected=%0h actual=%0h", $time, sig, want, got);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Local range leaves on port 0, the rest on port 1
	function automatic int port_for_dest(input logic [`NOC_NODE_ID_BW-1:0] dest);
		int d;
		d = int'(dest);
		if (d >= `NOC_LOCAL_BASE && d <= `NOC_LOCAL_LAST)
			return 0;
		return 1;
	endfunction

	// Input index sits in src_id of a head, in the top data bits of a body flit
	function automatic int source_of(input flit_t f);
		if (f.head)
			return int'(f.payload.hdr.src_id);
		return int'(f.payload.body.data[`NOC_DATA_BW-1 -: `NOC_NODE_ID_BW]);
	endfunction

	function automatic int pending_flits();
		int total;
		total = 0;
		for (int q = 0; q < NP*NP; q++)
			total += exp_q[q].size();
		return total;
	endfunction

	// ***********************************************************************
	// Checking
	// ***********************************************************************

	// Outputs quiet in reset and on the first edge out of it
	a_reset_quiet : assert property (
		@(posedge munoc_port_0)
		(!munoc_port_4 || $rose(munoc_port_4)) |-> (out_valid == '0)
	) else report_mismatch("out_valid", 32'(0), 32'(out_valid));

	// Stalled output holds flit and valid
	for (genvar go = 0; go < NP; go++)
	begin : g_hold
		a_out_hold : assert property (
			@(posedge munoc_port_0) disable iff (!munoc_port_4)
			out_valid[go] && !out_ready[go] |=> out_valid[go] && $stable(out_flit[go])
		) else fail_now($sformatf("output %0d changed or dropped a stalled flit", go));
	end

	task automatic check_output(input int o);
		int    src;
		flit_t want;
		src = source_of(out_flit[o]);
		a_src_known : assert (src < NP)
			else fail_now($sformatf("output %0d carries unknown source %0d", o, src));
		if (out_flit[o].head)
		begin
			a_tail_seen : assert (owner[o] == -1)
				else fail_now($sformatf("head on output %0d before previous tail", o));
			owner[o]    = src;
			out_dest[o] = out_flit[o].payload.hdr.dest_id;
		end
		a_no_interleave : assert (src == owner[o])
			else report_mismatch($sformatf("out_flit[%0d] source", o), 32'(owner[o]), 32'(src));
		a_right_port : assert (port_for_dest(out_dest[o]) == o)
			else report_mismatch("output port", 32'(port_for_dest(out_dest[o])), 32'(o));
		a_expected : assert (exp_q[src*NP + o].size() > 0)
			else fail_now($sformatf("unexpected flit from input %0d on output %0d", src, o));
		want = exp_q[src*NP + o].pop_front();
		a_intact : assert (out_flit[o] == want)
			else report_mismatch($sformatf("out_flit[%0d]", o), 32'(want), 32'(out_flit[o]));
		if (out_flit[o].tail)
			owner[o] = -1;
	endtask

	// Negedge sees the handshakes that complete on the next rising edge
	always @(negedge munoc_port_0)
	begin
		if (munoc_port_4)
		begin
			for (int i = 0; i < NP; i++)
				if (in_valid[i] && in_ready[i])
				begin
					if (in_flit[i].head)
						pkt_dest[i] = in_flit[i].payload.hdr.dest_id;
					exp_q[i*NP + port_for_dest(pkt_dest[i])].push_back(in_flit[i]);
				end
			for (int o = 0; o < NP; o++)
				if (out_valid[o] && out_ready[o])
					check_output(o);
		end
	end

	// ***********************************************************************
	// Stimulus
	// ***********************************************************************

	// Sink ready about three cycles in four
	always @(posedge munoc_port_0)
	begin
		#1;
		for (int o = 0; o < NP; o++)
			out_ready[o] = ($urandom_range(3, 0) != 0);
	end

	task automatic send_flit(input int src, input flit_t f);
		int   waited;
		logic took;
		in_flit[src]  = f;
		in_valid[src] = 1'b1;
		took   = 1'b0;
		waited = 0;
		while (!took)
		begin
			@(negedge munoc_port_0);
			took = in_ready[src];
			@(posedge munoc_port_0);
			#1;
			waited++;
			if (!took && waited > STALL_LIMIT)
				fail_now($sformatf("input %0d not ready for %0d cycles", src, waited));
		end
		in_valid[src] = 1'b0;
		// Occasional idle cycle between flits
		if ($urandom_range(3, 0) == 0)
		begin
			@(posedge munoc_port_0);
			#1;
		end
	endtask

	task automatic drive_input(input int src);
		int                         seq;
		int                         len;
		logic [`NOC_NODE_ID_BW-1:0] dest;
		flit_t                      f;
		seq = 0;
		for (int p = 0; p < PKTS; p++)
		begin
			dest = `NOC_NODE_ID_BW'($urandom_range(7, 0));
			len  = int'($urandom_range(4, 1));
			for (int k = 0; k < len; k++)
			begin
				f.head = (k == 0);
				f.tail = (k == len - 1);
				if (k == 0)
				begin
					f.payload.hdr.dest_id = dest;
					f.payload.hdr.src_id  = `NOC_NODE_ID_BW'(src);
					f.payload.hdr.tag     = TAG_BW'(seq);
				end
				else
					f.payload.body.data = {`NOC_NODE_ID_BW'(src), SEQ_BW'(seq)};
				send_flit(src, f);
				seq++;
			end
		end
	endtask

	initial
	begin
		int waited;
		void'($urandom(14));
		munoc_port_4 = 1'b0;
		in_valid     = '0;
		for (int i = 0; i < NP; i++)
			in_flit[i] = '0;
		repeat (10) @(posedge munoc_port_0);
		#1;
		munoc_port_4 = 1'b1;
		fork
			drive_input(0);
			drive_input(1);
		join
		// Everything accepted must come out
		waited = 0;
		while (pending_flits() != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge munoc_port_0);
			waited++;
		end
		if (pending_flits() == 0)
		begin
			$display("Simulation passed");
			$finish;
		end
		else
			fail_now($sformatf("%0d flits never left the router", pending_flits()));
	end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/noc_router_pkg.sv
hdl/flit_slice.sv
hdl/route_input_stage.sv
hdl/output_arbiter.sv
hdl/noc_router_top.sv
verif/noc_router_tb.sv

// ==== Makefile ====
# Verilator build and run for the router testbench

VERILATOR ?= verilator
TOP       ?= noc_router_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the pass text shows up in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
